/* Makefile */
SRCS := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv verification/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtilemap_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module tilemap_tb -o Vtilemap_tb

run: obj_dir/Vtilemap_tb
	@out=$$(./obj_dir/Vtilemap_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

/* rtl/tilemap_cpu_if.sv */
//////////////////////////////////////////////////
// Wishbone slave for tile map RAMs, scroll and flip registers
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_cpu_if (
    input  logic                    clk,
    input  logic                    rst,
    input  tilemap_pkg::wb_req_t    wb_req,
    output tilemap_pkg::wb_rsp_t    wb_rsp,
    output logic [`TM_VRAM_AW-1:0]  vram_adr,
    output logic [7:0]              vram_dat,
    output logic                    code_we,
    output logic                    attr_we,
    input  logic [7:0]              code_q,
    input  logic [7:0]              attr_q,
    output logic [7:0]              scroll,
    output logic                    flip
);

    localparam logic [11:0] adr_code = `TM_ADR_CODE;
    localparam logic [11:0] adr_attr = `TM_ADR_ATTR;

    logic       ack;
    logic       req;
    logic       wr_stb;
    logic       sel_code, sel_attr, sel_scroll, sel_flip;
    logic [7:0] rd_dat;

    assign req    = wb_req.cyc & wb_req.stb;
    assign wr_stb = req & wb_req.we & ~ack;   // Same edge that raises ack

    // RAM regions by the top two address bits
    assign sel_code   = wb_req.adr[11:10] == adr_code[11:10];
    assign sel_attr   = wb_req.adr[11:10] == adr_attr[11:10];
    assign sel_scroll = wb_req.adr == `TM_ADR_SCROLL;
    assign sel_flip   = wb_req.adr == `TM_ADR_FLIP;

    assign vram_adr = wb_req.adr[`TM_VRAM_AW-1:0];
    assign vram_dat = wb_req.dat;
    assign code_we  = wr_stb & sel_code;
    assign attr_we  = wr_stb & sel_attr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack    <= 1'b0;
            scroll <= 8'd0;
            flip   <= 1'b0;
        end else begin
            ack <= req & ~ack;              // One clock, then wait for the next cycle
            if (wr_stb && sel_scroll) scroll <= wb_req.dat;
            if (wr_stb && sel_flip)   flip   <= wb_req.dat[0];
        end
    end

    // RAM q is already registered on the ack edge
    always_comb begin
        rd_dat = 8'h00;
        if (sel_code)
            rd_dat = code_q;
        else if (sel_attr)
            rd_dat = attr_q;
        else if (sel_scroll)
            rd_dat = scroll;
        else if (sel_flip)
            rd_dat = {7'd0, flip};
    end

    assign wb_rsp.dat = rd_dat;
    assign wb_rsp.ack = ack;

    // Master must drop stb after ack, so ack stays a single pulse
    a_ack_single : assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

`default_nettype wire

/* rtl/tilemap_defs.svh */
//////////////////////////////////////////////////
// Screen geometry, memory widths and bus map of the tile layer
// Included by the package, the RTL and the testbench
//////////////////////////////////////////////////
`ifndef TILEMAP_DEFS_SVH
`define TILEMAP_DEFS_SVH

// Beam geometry in pixel clock ticks and lines
`define TM_HTOTAL      320
`define TM_HVIS        256
`define TM_VTOTAL      264
`define TM_VVIS        224

`define TM_VRAM_AW     10      // 32x32 tile map
`define TM_ROM_AW      13      // Code msb, code, row
`define TM_PAL_AW      8       // Palette bank and pixel

// Wishbone byte addresses
`define TM_ADR_CODE    12'h000
`define TM_ADR_ATTR    12'h400
`define TM_ADR_SCROLL  12'h800
`define TM_ADR_FLIP    12'h801

`endif

/* rtl/tilemap_fetch.sv */
//////////////////////////////////////////////////
// Scrolled tile scan, graphics ROM fetch and pixel shifter
// One tile is addressed while the previous one shifts out
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  tilemap_pkg::video_pos_t pos,
    input  logic [7:0]              scroll,
    input  logic                    flip,
    output logic [`TM_VRAM_AW-1:0]  scan_adr,
    input  logic [7:0]              code,
    input  tilemap_pkg::tile_attr_t attr,
    output logic [`TM_ROM_AW-1:0]   rom_addr,
    input  logic [31:0]             rom_data,
    output tilemap_pkg::layer_pxl_t lyr
);

    localparam int unsigned blank_dly = 7;  // Beam to shifter output

    logic [7:0]           hdf;          // Column after screen flip
    logic [7:0]           row;          // Scrolled map row
    logic [2:0]           rsel;
    logic                 cap;
    logic                 load;
    logic [31:0]          row_swz;
    logic [31:0]          row_hold;
    logic                 hold_hf;
    logic [3:0]           hold_pal;
    logic [31:0]          shf;
    logic                 shf_hf;
    logic [3:0]           shf_pal;
    logic [blank_dly-1:0] hbl_dly, vbl_dly;

    assign hdf = pos.hdump[7:0] ^ {8{flip}};

    // Row for the next line, taken once the visible part ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            row <= 8'd0;
        else if (pos.pxl_cen && pos.hdump == 9'(`TM_HVIS))
            row <= {8{flip}} ^ (pos.vdump[7:0] + scroll);
    end

    assign scan_adr = {row[7:3], hdf[7:3]};
    assign rsel     = row[2:0] ^ {3{attr.vflip}};
    assign rom_addr = {attr.code_msb, code, rsel};  // 2+8+3

    // ROM word holds four interleaved bit planes
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            for (int n = 0; n < 4; n++) begin
                for (int b = 0; b < 4; b++) begin
                    row_swz[31 - h*16 - n*4 - b] = rom_data[(1-h)*16 + 15 - n - 4*b];
                end
            end
        end
    end

    assign cap  = pos.pxl_cen && hdf[2:0] == 3'd1;        // ROM settled by now
    assign load = pos.pxl_cen && pos.hdump[2:0] == 3'd6;  // Fixed beam phase

    always_ff @(posedge clk) begin
        if (cap) begin
            row_hold <= row_swz;
            hold_hf  <= attr.hflip ^ flip;  // Screen flip reverses tile order too
            hold_pal <= attr.pal;
        end
        if (load) begin
            // Flipped screen captures on the load tick itself
            shf     <= cap ? row_swz : row_hold;
            shf_hf  <= cap ? (attr.hflip ^ flip) : hold_hf;
            shf_pal <= cap ? attr.pal : hold_pal;
        end else if (pos.pxl_cen) begin
            shf <= shf_hf ? shf >> 4 : shf << 4;
        end
    end

    // Blanking follows the pixel through the same depth
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hbl_dly <= '0;
            vbl_dly <= '0;
        end else if (pos.pxl_cen) begin
            hbl_dly <= {hbl_dly[blank_dly-2:0], pos.lhbl};
            vbl_dly <= {vbl_dly[blank_dly-2:0], pos.lvbl};
        end
    end

    assign lyr.pal  = shf_pal;
    assign lyr.pix  = shf_hf ? shf[3:0] : shf[31:28];
    assign lyr.lhbl = hbl_dly[blank_dly-1];
    assign lyr.lvbl = vbl_dly[blank_dly-1];

endmodule

`default_nettype wire

/* rtl/tilemap_palette.sv */
//////////////////////////////////////////////////
// Palette PROM lookup with blanking kept in step
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_palette (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  tilemap_pkg::layer_pxl_t lyr,
    input  tilemap_pkg::prom_wr_t   prom,
    output logic [3:0]              pxl,
    output logic                    lhbl,
    output logic                    lvbl
);

    logic [3:0]            mem [0:(1<<`TM_PAL_AW)-1];
    logic [`TM_PAL_AW-1:0] rd_adr;
    logic                  vis;

    // Programming port, one write per clk
    always_ff @(posedge clk) begin
        if (prom.we)
            mem[prom.addr] <= prom.data;
    end

    assign rd_adr = {lyr.pal, lyr.pix};   // Bank then pixel
    assign vis    = lyr.lhbl & lyr.lvbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl  <= 4'd0;
            lhbl <= 1'b0;   // Blanked out of reset
            lvbl <= 1'b0;
        end else if (pxl_cen) begin
            pxl  <= vis ? mem[rd_adr] : 4'd0;
            lhbl <= lyr.lhbl;
            lvbl <= lyr.lvbl;
        end
    end

endmodule

`default_nettype wire

/* rtl/tilemap_pkg.sv */
//////////////////////////////////////////////////
// Shared bus, attribute, beam and pixel types of the tile layer
//////////////////////////////////////////////////
`default_nettype none

`include "tilemap_defs.svh"

package tilemap_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic [11:0] adr;   // Code RAM, attr RAM, registers
        logic [7:0]  dat;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [7:0] dat;    // Valid with ack
        logic       ack;
    } wb_rsp_t;

    // Attribute RAM byte
    typedef struct packed {
        logic [1:0] code_msb;
        logic       vflip;
        logic       hflip;
        logic [3:0] pal;
    } tile_attr_t;

    // Beam position from the timing block
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;   // High while visible
        logic       lvbl;
        logic       pxl_cen;
    } video_pos_t;

    // Fetch to palette
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] pix;
        logic       lhbl;
        logic       lvbl;
    } layer_pxl_t;

    // Palette PROM programming
    typedef struct packed {
        logic [`TM_PAL_AW-1:0] addr;
        logic [3:0]            data;
        logic                  we;
    } prom_wr_t;

endpackage

`default_nettype wire

/* rtl/tilemap_top.sv */
//////////////////////////////////////////////////
// Tile layer top: CPU bus in, graphics ROM fetch, colour index out
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    // CPU
    input  tilemap_pkg::wb_req_t   wb_req,
    output tilemap_pkg::wb_rsp_t   wb_rsp,
    // Palette programming
    input  tilemap_pkg::prom_wr_t  prom,
    // Graphics ROM
    output logic [`TM_ROM_AW-1:0]  rom_addr,
    input  logic [31:0]            rom_data,
    // Video
    output logic [3:0]             pxl,
    output logic                   lhbl,
    output logic                   lvbl
);

    import tilemap_pkg::*;

    logic [`TM_VRAM_AW-1:0] vram_adr;
    logic [7:0]             vram_dat;
    logic                   code_we, attr_we;
    logic [7:0]             code_q, attr_q;
    logic [7:0]             scroll;
    logic                   flip;
    logic [`TM_VRAM_AW-1:0] scan_adr;
    logic [7:0]             code;
    tile_attr_t             attr;
    video_pos_t             pos;
    layer_pxl_t             lyr;

    tilemap_cpu_if i_cpu_if (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .vram_adr (vram_adr),
        .vram_dat (vram_dat),
        .code_we  (code_we),
        .attr_we  (attr_we),
        .code_q   (code_q),
        .attr_q   (attr_q),
        .scroll   (scroll),
        .flip     (flip)
    );

    tilemap_video_timing i_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .pos     (pos)
    );

    // Tile codes
    tilemap_vram i_code_ram (
        .clk      (clk),
        .cpu_adr  (vram_adr),
        .cpu_dat  (vram_dat),
        .cpu_we   (code_we),
        .cpu_q    (code_q),
        .scan_adr (scan_adr),
        .scan_q   (code)
    );

    // Tile attributes, same scan address
    tilemap_vram i_attr_ram (
        .clk      (clk),
        .cpu_adr  (vram_adr),
        .cpu_dat  (vram_dat),
        .cpu_we   (attr_we),
        .cpu_q    (attr_q),
        .scan_adr (scan_adr),
        .scan_q   (attr)
    );

    tilemap_fetch i_fetch (
        .clk      (clk),
        .rst      (rst),
        .pos      (pos),
        .scroll   (scroll),
        .flip     (flip),
        .scan_adr (scan_adr),
        .code     (code),
        .attr     (attr),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .lyr      (lyr)
    );

    tilemap_palette i_palette (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lyr     (lyr),
        .prom    (prom),
        .pxl     (pxl),
        .lhbl    (lhbl),
        .lvbl    (lvbl)
    );

endmodule

`default_nettype wire

/* rtl/tilemap_video_timing.sv */
//////////////////////////////////////////////////
// Beam counters and blanking, stepped by the pixel clock enable
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_video_timing (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    output tilemap_pkg::video_pos_t pos
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       h_last;

    assign h_last = hcnt == 9'(`TM_HTOTAL - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= 9'd0;
            vcnt <= 9'd0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcnt <= 9'd0;
                // Line advance on horizontal wrap
                if (vcnt == 9'(`TM_VTOTAL - 1))
                    vcnt <= 9'd0;
                else
                    vcnt <= vcnt + 9'd1;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    assign pos.hdump   = hcnt;
    assign pos.vdump   = vcnt;
    assign pos.lhbl    = hcnt < 9'(`TM_HVIS);   // High while visible
    assign pos.lvbl    = vcnt < 9'(`TM_VVIS);
    assign pos.pxl_cen = pxl_cen;                // Fetch steps on the same tick

    a_h_range : assert property (@(posedge clk) disable iff (rst)
        hcnt < 9'(`TM_HTOTAL));

endmodule

`default_nettype wire

/* rtl/tilemap_vram.sv */
//////////////////////////////////////////////////
// Tile map byte RAM with CPU read/write port and scan read port
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_vram (
    input  logic                   clk,
    // CPU side
    input  logic [`TM_VRAM_AW-1:0] cpu_adr,
    input  logic [7:0]             cpu_dat,
    input  logic                   cpu_we,
    output logic [7:0]             cpu_q,
    // Video scan, read only
    input  logic [`TM_VRAM_AW-1:0] scan_adr,
    output logic [7:0]             scan_q
);

    logic [7:0] mem [0:(1<<`TM_VRAM_AW)-1];

    // CPU port returns the written byte on a write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_adr] <= cpu_dat;
            cpu_q        <= cpu_dat;
        end else begin
            cpu_q <= mem[cpu_adr];
        end
    end

    always_ff @(posedge clk) begin
        scan_q <= mem[scan_adr];    // One clk read latency
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
+incdir+verification
rtl/tilemap_pkg.sv
rtl/tilemap_cpu_if.sv
rtl/tilemap_vram.sv
rtl/tilemap_video_timing.sv
rtl/tilemap_fetch.sv
rtl/tilemap_palette.sv
rtl/tilemap_top.sv
verification/tilemap_tb.sv

/* verification/tilemap_model.svh */
//////////////////////////////////////////////////
// Expected colour of a screen pixel, included in the tile layer testbench
//////////////////////////////////////////////////
`ifndef TILEMAP_MODEL_SVH
`define TILEMAP_MODEL_SVH

// Pixel i of a ROM row; pixels 0-3 in the upper half, planes at stride 4
function automatic logic [3:0] plane_pixel(input logic [31:0] word, input int i);
    logic [3:0] v;
    int         half;
    int         n;
    half = i / 4;
    n    = i % 4;
    for (int p = 0; p < 4; p++) begin
        v[3-p] = word[(1-half)*16 + 15 - n - 4*p];   // One bit per plane
    end
    return v;
endfunction

// Colour at visible position (x, y) from the bench copies
function automatic logic [3:0] expected_colour(input int x, input int y);
    logic [8:0]  prev_line;
    logic [7:0]  row;
    logic [7:0]  col;
    logic [9:0]  idx;
    tile_attr_t  a;
    logic [2:0]  line;
    logic [31:0] word;
    logic [3:0]  pix;
    // Row is latched in the previous line's blanking
    prev_line = (y == 0) ? 9'(`TM_VTOTAL - 1) : 9'(y - 1);
    row  = (prev_line[7:0] + scroll_q) ^ {8{flip_q}};
    col  = 8'(x) ^ {8{flip_q}};
    idx  = {row[7:3], col[7:3]};
    a    = attr_mem[idx];
    line = row[2:0] ^ {3{a.vflip}};
    word = rom_mem[{a.code_msb, code_mem[idx], line}];
    pix  = plane_pixel(word, int'(col[2:0] ^ {3{a.hflip}}));
    return prom_mem[{a.pal, pix}];
endfunction

`endif

/* verification/tilemap_tb.sv */
//////////////////////////////////////////////////
// Testbench of the tile layer: bus access, frames with scroll and flips
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "tilemap_defs.svh"

module tilemap_tb;

    import tilemap_pkg::*;

    localparam int frame_clks   = `TM_HTOTAL * `TM_VTOTAL * 2;
    localparam int timeout_clks = 12 * frame_clks + 20000;  // Setup, syncs and 4 frames

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    prom_wr_t    prom;
    logic [12:0] rom_addr;
    logic [31:0] rom_data;
    logic [3:0]  pxl;
    logic        lhbl, lvbl;

    // Bench copies of everything the picture depends on
    logic [7:0]  code_mem [0:1023];
    logic [7:0]  attr_mem [0:1023];
    logic [31:0] rom_mem  [0:8191];
    logic [3:0]  prom_mem [0:255];
    logic [7:0]  scroll_q;
    logic        flip_q;
    integer      seed = 2634;
    bit          armed = 0;
    int          frames_checked = 0;

    `include "tilemap_model.svh"

    tilemap_top i_tilemap_top (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .prom     (prom),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .pxl      (pxl),
        .lhbl     (lhbl),
        .lvbl     (lvbl)
    );

    always #20 clk = ~clk;
    always @(negedge clk) pxl_cen <= ~pxl_cen;   // Every second clk
    always @(posedge clk) rom_data <= rom_mem[rom_addr];  // One clk latency

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input logic [11:0] adr, input wb_rsp_t got, input wb_rsp_t exp);
        if (got !== exp)
            report_fail($sformatf("** Error: wb_rsp at adr %h got %h expected %h",
                adr, got, exp));
    endtask

    task automatic check_pxl(input int x, input int y, input logic [3:0] got,
                             input logic [3:0] exp);
        if (got !== exp)
            report_fail($sformatf("** Error: pxl at x %0d y %0d got %h expected %h",
                x, y, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            report_fail($sformatf("** Error: %s got %h expected %h", what, got, exp));
    endtask

    // One classic cycle; returns the response seen with ack
    task automatic bus_cycle(input logic [11:0] adr, input logic [7:0] dat, input logic we,
                             output wb_rsp_t rsp);
        int n;
        n = 0;
        wb_req = '{adr: adr, dat: dat, we: we, cyc: 1'b1, stb: 1'b1};
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < 16);
        if (!wb_rsp.ack)
            report_fail($sformatf("No ack from the bus at address %h", adr));
        rsp    = wb_rsp;
        wb_req = '0;
        @(negedge clk);
        if (wb_rsp.ack)
            report_fail($sformatf("Ack held longer than one clock at address %h", adr));
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [7:0] dat);
        wb_rsp_t rsp;
        bus_cycle(adr, dat, 1'b1, rsp);
    endtask

    task automatic bus_read_check(input logic [11:0] adr, input logic [7:0] exp);
        wb_rsp_t rsp;
        bus_cycle(adr, 8'h00, 1'b0, rsp);
        check_rsp(adr, rsp, '{dat: exp, ack: 1'b1});
    endtask

    // Apply settings in vertical blanking, then check the next whole frame
    task automatic run_frame(input logic [7:0] scr, input logic flp, input bit new_attr);
        int start;
        do @(negedge clk); while (!lvbl);
        do @(negedge clk); while (lvbl);
        if (new_attr) begin
            for (int i = 0; i < 1024; i++) begin
                attr_mem[i] = 8'($random(seed));   // Random hflip and vflip too
                bus_write(`TM_ADR_ATTR + 12'(i), attr_mem[i]);
            end
        end
        scroll_q = scr;
        flip_q   = flp;
        bus_write(`TM_ADR_SCROLL, scr);
        bus_write(`TM_ADR_FLIP, {7'd0, flp});
        start = frames_checked;
        armed = 1;
        wait (frames_checked > start);
    endtask

    // Compare process, one sample per pixel tick
    initial begin
        int x, y;
        bit checking;
        logic prev_lhbl, prev_lvbl;
        x = 0;
        y = 0;
        checking = 0;
        prev_lhbl = 0;
        prev_lvbl = 0;
        forever begin
            @(posedge clk);
            if (!rst && pxl_cen) begin
                @(negedge clk);
                if (lvbl && !prev_lvbl) begin
                    checking = armed;
                    armed = 0;
                    x = 0;
                    y = 0;
                end
                if (checking && lvbl && !lhbl && prev_lhbl) begin
                    check_count("visible pixels in line", x, `TM_HVIS);
                    y++;
                    x = 0;
                end
                if (checking && !lvbl && prev_lvbl) begin
                    check_count("visible lines in frame", y, `TM_VVIS);
                    checking = 0;
                    frames_checked++;
                end
                if (lhbl && lvbl) begin
                    if (checking)
                        check_pxl(x, y, pxl, expected_colour(x, y));
                    x++;
                end else begin
                    check_pxl(x, y, pxl, 4'h0);   // Blanked pixel
                end
                prev_lhbl = lhbl;
                prev_lvbl = lvbl;
            end
        end
    end

    initial begin
        for (int c = 0; c < timeout_clks; c++)
            @(posedge clk);
        $display("Timeout: the run did not finish in %0d clocks", timeout_clks);
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        clk      = 0;
        rst      = 1;
        pxl_cen  = 0;
        wb_req   = '0;
        prom     = '0;
        rom_data = '0;
        scroll_q = 8'd0;
        flip_q   = 1'b0;
        for (int i = 0; i < 8192; i++) rom_mem[i] = $random(seed);
        for (int i = 0; i < 256; i++) prom_mem[i] = 4'($random(seed));
        for (int i = 0; i < 1024; i++) begin
            code_mem[i] = 8'($random(seed));
            attr_mem[i] = 8'($random(seed)) & 8'hcf;   // No tile flips yet
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 0;

        for (int i = 0; i < 256; i++) begin
            prom = '{addr: 8'(i), data: prom_mem[i], we: 1'b1};
            @(negedge clk);
        end
        prom = '0;

        // Bus access and read back
        for (int i = 0; i < 1024; i++) begin
            bus_write(`TM_ADR_CODE + 12'(i), code_mem[i]);
            bus_write(`TM_ADR_ATTR + 12'(i), attr_mem[i]);
        end
        scroll_q = 8'($random(seed));
        flip_q   = 1'($random(seed));
        bus_write(`TM_ADR_SCROLL, scroll_q);
        bus_write(`TM_ADR_FLIP, {7'd0, flip_q});
        for (int i = 0; i < 1024; i++) begin
            bus_read_check(`TM_ADR_CODE + 12'(i), code_mem[i]);
            bus_read_check(`TM_ADR_ATTR + 12'(i), attr_mem[i]);
        end
        bus_read_check(`TM_ADR_SCROLL, scroll_q);
        bus_read_check(`TM_ADR_FLIP, {7'd0, flip_q});

        run_frame(8'd0, 1'b0, 0);                // Plain
        run_frame(8'($random(seed)), 1'b0, 0);   // Vertical scroll
        run_frame(8'($random(seed)), 1'b0, 1);   // Tile flips
        run_frame(8'($random(seed)), 1'b1, 0);   // Screen flip

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
